// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= voice_loop_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= sim.f
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "FAIL: see $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim.f ====
src/voice_loop_pkg.sv
src/codec_power_up.sv
src/i2s_rx.sv
src/voice_effect.sv
src/i2s_tx.sv
src/voice_loop_top.sv
verif/voice_loop_assert.sv
verif/voice_loop_tb.sv

// ==== src/codec_power_up.sv ====
`default_nettype none

module codec_power_up
(
    input  wire  clk_12M,
    input  wire  reset,
    input  wire  key,                 // held high to run the loop
    output logic path_ready           // codec path may run
);

    logic [voice_loop_pkg::powerup_w-1:0] cnt;       // cycles since key went high
    logic [voice_loop_pkg::powerup_w-1:0] cnt_next;  // saturating next count

    //////////////////////////////////////////////////
    // hold-off counter
    //////////////////////////////////////////////////
    always_comb
    begin
        if (cnt == (voice_loop_pkg::powerup_w)'(voice_loop_pkg::powerup_cycles))
        begin
            cnt_next = cnt;           // parked at the end
        end
        else
        begin
            cnt_next = cnt + 1'b1;
        end
    end

    // ready lines up with the count reaching the limit, not one cycle late
    always_ff @(posedge clk_12M)
    begin
        if (reset || !key)
        begin
            cnt        <= '0;         // key release restarts the wait
            path_ready <= 1'b0;
        end
        else
        begin
            cnt        <= cnt_next;
            path_ready <= (cnt_next ==
                           (voice_loop_pkg::powerup_w)'(voice_loop_pkg::powerup_cycles));
        end
    end

endmodule

`default_nettype wire

// ==== src/i2s_rx.sv ====
`default_nettype none

module i2s_rx
(
    input  wire                                   clk_12M,
    input  wire                                   reset,
    input  wire                                   path_ready,
    input  wire                                   sck,        // codec bit clock
    input  wire                                   ws,         // low = left word
    input  wire                                   sd,         // serial data from adc
    output logic                                  rx_req,
    output logic [voice_loop_pkg::sample_w-1:0]   rx_left,
    output logic [voice_loop_pkg::sample_w-1:0]   rx_right,
    input  wire                                   rx_ack,
    output logic                                  overrun     // sticky, frame dropped
);

    logic [voice_loop_pkg::sync_stages-1:0] sck_sync;   // sck into clk_12M
    logic [voice_loop_pkg::sync_stages-1:0] ws_sync;
    logic [voice_loop_pkg::sync_stages-1:0] sd_sync;
    logic                                   sck_s;      // synchronized copies
    logic                                   ws_s;
    logic                                   sd_s;
    logic                                   sck_last;   // edge register
    logic                                   sck_rise;
    logic                                   ws_prev;    // ws at the previous rising sck
    logic [voice_loop_pkg::sample_w-1:0]    left_sh;    // words being assembled
    logic [voice_loop_pkg::sample_w-1:0]    right_sh;
    logic                                   armed;      // seen one frame boundary
    logic                                   frame_done; // right LSB just sampled
    logic                                   capture;    // frame goes to the link

    assign sck_s    = sck_sync[voice_loop_pkg::sync_stages-1];
    assign ws_s     = ws_sync[voice_loop_pkg::sync_stages-1];
    assign sd_s     = sd_sync[voice_loop_pkg::sync_stages-1];
    assign sck_rise = sck_s && !sck_last;

    // ws already shows the next word when the LSB of the current one arrives
    assign frame_done = sck_rise && ws_prev && !ws_s;
    assign capture    = frame_done && armed && !rx_req && !rx_ack;

    //////////////////////////////////////////////////
    // input synchronizer and edge detect
    //////////////////////////////////////////////////
    always_ff @(posedge clk_12M)
    begin
        if (reset)
        begin
            sck_sync <= '0;
            ws_sync  <= '0;
            sd_sync  <= '0;
            sck_last <= 1'b0;
            ws_prev  <= 1'b0;
        end
        else
        begin
            sck_sync <= {sck_sync[voice_loop_pkg::sync_stages-2:0], sck};
            ws_sync  <= {ws_sync[voice_loop_pkg::sync_stages-2:0], ws};
            sd_sync  <= {sd_sync[voice_loop_pkg::sync_stages-2:0], sd};
            sck_last <= sck_s;
            if (sck_rise)
                ws_prev <= ws_s;      // word select for this bit
        end
    end

    //////////////////////////////////////////////////
    // deserializer, MSB first
    //////////////////////////////////////////////////
    always_ff @(posedge clk_12M)
    begin
        if (sck_rise)
        begin
            if (ws_prev)
                right_sh <= {right_sh[voice_loop_pkg::sample_w-2:0], sd_s};
            else
                left_sh  <= {left_sh[voice_loop_pkg::sample_w-2:0], sd_s};
        end
        if (capture)
        begin
            rx_left  <= left_sh;
            rx_right <= {right_sh[voice_loop_pkg::sample_w-2:0], sd_s}; // includes LSB
        end
    end

    // handshake source side, first boundary after ready only aligns
    always_ff @(posedge clk_12M)
    begin
        if (reset || !path_ready)
        begin
            rx_req  <= 1'b0;
            overrun <= 1'b0;
            armed   <= 1'b0;
        end
        else
        begin
            if (rx_req && rx_ack)
                rx_req <= 1'b0;       // sink has the data
            if (frame_done)
                armed <= 1'b1;
            if (capture)
                rx_req <= 1'b1;
            else if (frame_done && armed)
                overrun <= 1'b1;      // previous frame still in the link
        end
    end

endmodule

`default_nettype wire

// ==== src/i2s_tx.sv ====
`default_nettype none

module i2s_tx
(
    input  wire                                   clk_12M,
    input  wire                                   reset,
    input  wire                                   path_ready,
    input  wire                                   sck,        // dac bit clock
    input  wire                                   ws,         // dac word select
    output logic                                  sd,         // serial data to dac
    input  wire                                   fx_req,
    input  wire  [voice_loop_pkg::sample_w-1:0]   fx_left,
    input  wire  [voice_loop_pkg::sample_w-1:0]   fx_right,
    output logic                                  fx_ack
);

    logic [voice_loop_pkg::sync_stages-1:0]    sck_sync;    // sck into clk_12M
    logic [voice_loop_pkg::sync_stages-1:0]    ws_sync;
    logic                                      sck_s;
    logic                                      ws_s;
    logic                                      sck_last;    // edge register
    logic                                      sck_rise;
    logic                                      sck_fall;
    logic                                      ws_prev;     // ws at previous rising sck
    logic                                      frame_start; // left word begins
    logic                                      take;        // pending frame loaded
    logic [voice_loop_pkg::bits_per_frame-1:0] shreg;       // left in the high half

    assign sck_s    = sck_sync[voice_loop_pkg::sync_stages-1];
    assign ws_s     = ws_sync[voice_loop_pkg::sync_stages-1];
    assign sck_rise = sck_s && !sck_last;
    assign sck_fall = !sck_s && sck_last;

    // ws sampled mid-bit on rising sck, well away from its own transition
    assign frame_start = sck_rise && ws_prev && !ws_s;
    assign take        = frame_start && fx_req && !fx_ack;

    //////////////////////////////////////////////////
    // input synchronizer and edge detect
    //////////////////////////////////////////////////
    always_ff @(posedge clk_12M)
    begin
        if (reset)
        begin
            sck_sync <= '0;
            ws_sync  <= '0;
            sck_last <= 1'b0;
            ws_prev  <= 1'b0;
        end
        else
        begin
            sck_sync <= {sck_sync[voice_loop_pkg::sync_stages-2:0], sck};
            ws_sync  <= {ws_sync[voice_loop_pkg::sync_stages-2:0], ws};
            sck_last <= sck_s;
            if (sck_rise)
                ws_prev <= ws_s;
        end
    end

    //////////////////////////////////////////////////
    // frame load, ack and serializer
    //////////////////////////////////////////////////
    always_ff @(posedge clk_12M)
    begin
        if (reset || !path_ready)
        begin
            fx_ack <= 1'b0;
            shreg  <= '0;
            sd     <= 1'b0;           // dac line quiet while idle
        end
        else
        begin
            if (take)
                fx_ack <= 1'b1;
            else if (!fx_req)
                fx_ack <= 1'b0;       // four-phase return
            if (frame_start)
            begin
                if (take)
                    shreg <= {fx_left, fx_right};
                else
                    shreg <= '0;      // nothing pending, silent frame
            end
            else if (sck_fall)
            begin
                sd    <= shreg[voice_loop_pkg::bits_per_frame-1]; // MSB first
                shreg <= {shreg[voice_loop_pkg::bits_per_frame-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/voice_effect.sv ====
`default_nettype none

module voice_effect
(
    input  wire                                   clk_12M,
    input  wire                                   reset,
    input  wire                                   path_ready,
    input  wire  [3:0]                            key_diff,   // one-hot effect select
    input  wire                                   rx_req,
    input  wire  [voice_loop_pkg::sample_w-1:0]   rx_left,
    input  wire  [voice_loop_pkg::sample_w-1:0]   rx_right,
    output logic                                  rx_ack,
    output logic                                  fx_req,
    output logic [voice_loop_pkg::sample_w-1:0]   fx_left,
    output logic [voice_loop_pkg::sample_w-1:0]   fx_right,
    input  wire                                   fx_ack
);

    logic [voice_loop_pkg::sample_w-1:0]    in_left;    // accepted frame
    logic [voice_loop_pkg::sample_w-1:0]    in_right;
    logic [3:0]                             in_mode;    // key at acceptance
    logic                                   accept;
    logic                                   calc;       // result registers next edge
    logic signed [voice_loop_pkg::ext_w-1:0] sum;
    logic signed [voice_loop_pkg::ext_w-1:0] diff;
    logic signed [voice_loop_pkg::ext_w-1:0] avg_ext;   // centre
    logic signed [voice_loop_pkg::ext_w-1:0] side_ext;  // side
    logic [voice_loop_pkg::sample_w-1:0]    res_left;
    logic [voice_loop_pkg::sample_w-1:0]    res_right;

    // only one frame held here, the output link must be fully idle
    assign accept = rx_req && !rx_ack && !calc && !fx_req && !fx_ack;

    //////////////////////////////////////////////////
    // effect arithmetic
    //////////////////////////////////////////////////
    assign sum  = $signed({in_left[voice_loop_pkg::sample_w-1], in_left})
                + $signed({in_right[voice_loop_pkg::sample_w-1], in_right});
    assign diff = $signed({in_left[voice_loop_pkg::sample_w-1], in_left})
                - $signed({in_right[voice_loop_pkg::sample_w-1], in_right});
    assign avg_ext  = sum >>> 1;      // rounds toward minus infinity
    assign side_ext = diff >>> 1;     // halved result always fits 16 bits

    always_comb
    begin
        case (in_mode)
            voice_loop_pkg::mode_left:
            begin
                res_left  = in_left;
                res_right = in_left;
            end
            voice_loop_pkg::mode_right:
            begin
                res_left  = in_right;
                res_right = in_right;
            end
            voice_loop_pkg::mode_no_music:
            begin
                res_left  = avg_ext[voice_loop_pkg::sample_w-1:0];
                res_right = avg_ext[voice_loop_pkg::sample_w-1:0];
            end
            voice_loop_pkg::mode_no_vocals:
            begin
                res_left  = side_ext[voice_loop_pkg::sample_w-1:0];
                res_right = side_ext[voice_loop_pkg::sample_w-1:0];
            end
            voice_loop_pkg::mode_pass:
            begin
                res_left  = in_left;
                res_right = in_right;
            end
            default:
            begin
                res_left  = in_left;      // unlisted pattern, pass
                res_right = in_right;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // frame registers and both handshakes
    //////////////////////////////////////////////////
    always_ff @(posedge clk_12M)
    begin
        if (accept)
        begin
            in_left  <= rx_left;
            in_right <= rx_right;
            in_mode  <= key_diff;     // mode fixed per frame
        end
        if (calc)
        begin
            fx_left  <= res_left;
            fx_right <= res_right;
        end
    end

    always_ff @(posedge clk_12M)
    begin
        if (reset || !path_ready)
        begin
            rx_ack <= 1'b0;
            calc   <= 1'b0;
            fx_req <= 1'b0;
        end
        else
        begin
            calc <= accept;
            if (accept)
                rx_ack <= 1'b1;
            else if (!rx_req)
                rx_ack <= 1'b0;       // source let go
            if (calc)
                fx_req <= 1'b1;
            else if (fx_ack)
                fx_req <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/voice_loop_pkg.sv ====
`default_nettype none

package voice_loop_pkg;

    //////////////////////////////////////////////////
    // sample and frame geometry
    //////////////////////////////////////////////////
    localparam int sample_w       = 16;               // one channel, two's complement
    localparam int bits_per_frame = 2 * sample_w;     // left word then right word, 32 sck
    localparam int ext_w          = sample_w + 1;     // sum and difference need one more bit

    //////////////////////////////////////////////////
    // effect selection, one-hot key patterns
    //////////////////////////////////////////////////
    localparam logic [3:0] mode_pass      = 4'b0000;  // straight through
    localparam logic [3:0] mode_left      = 4'b0001;  // left on both outputs
    localparam logic [3:0] mode_right     = 4'b0010;  // right on both outputs
    localparam logic [3:0] mode_no_music  = 4'b0100;  // centre, (l + r) / 2
    localparam logic [3:0] mode_no_vocals = 4'b1000;  // side, (l - r) / 2
    // any other key pattern falls back to passthrough

    //////////////////////////////////////////////////
    // power-up and synchronizer
    //////////////////////////////////////////////////
    // short hold-off for simulation; silicon wants the long millisecond count
    localparam int powerup_cycles = 64;
    localparam int powerup_w      = $clog2(powerup_cycles + 1); // counter width

    // flops between the codec pins and the clk_12M logic
    localparam int sync_stages    = 2;

endpackage

`default_nettype wire

// ==== src/voice_loop_top.sv ====
`default_nettype none

module voice_loop_top
(
    input  wire        clk_12M,       // also the codec master clock
    input  wire        reset,
    input  wire        key,           // held high to run
    input  wire  [3:0] key_diff,      // effect select
    input  wire        adc_sck,
    input  wire        adc_ws,
    input  wire        adc_sd,
    input  wire        dac_sck,
    input  wire        dac_ws,
    output logic       dac_sd,
    output logic       path_ready,
    output logic       overrun
);

    //////////////////////////////////////////////////
    // internal frame links
    //////////////////////////////////////////////////
    logic                                rx_req;    // rx_to_fx
    logic                                rx_ack;
    logic [voice_loop_pkg::sample_w-1:0] rx_left;
    logic [voice_loop_pkg::sample_w-1:0] rx_right;
    logic                                fx_req;    // fx_to_tx
    logic                                fx_ack;
    logic [voice_loop_pkg::sample_w-1:0] fx_left;
    logic [voice_loop_pkg::sample_w-1:0] fx_right;

    codec_power_up power_up_i
    (
        .clk_12M    (clk_12M),
        .reset      (reset),
        .key        (key),
        .path_ready (path_ready)
    );

    i2s_rx rx_i
    (
        .clk_12M    (clk_12M),
        .reset      (reset),
        .path_ready (path_ready),
        .sck        (adc_sck),
        .ws         (adc_ws),
        .sd         (adc_sd),
        .rx_req     (rx_req),
        .rx_left    (rx_left),
        .rx_right   (rx_right),
        .rx_ack     (rx_ack),
        .overrun    (overrun)
    );

    voice_effect effect_i
    (
        .clk_12M    (clk_12M),
        .reset      (reset),
        .path_ready (path_ready),
        .key_diff   (key_diff),
        .rx_req     (rx_req),
        .rx_left    (rx_left),
        .rx_right   (rx_right),
        .rx_ack     (rx_ack),
        .fx_req     (fx_req),
        .fx_left    (fx_left),
        .fx_right   (fx_right),
        .fx_ack     (fx_ack)
    );

    i2s_tx tx_i
    (
        .clk_12M    (clk_12M),
        .reset      (reset),
        .path_ready (path_ready),
        .sck        (dac_sck),
        .ws         (dac_ws),
        .sd         (dac_sd),
        .fx_req     (fx_req),
        .fx_left    (fx_left),
        .fx_right   (fx_right),
        .fx_ack     (fx_ack)
    );

endmodule

`default_nettype wire

// ==== verif/voice_loop_assert.sv ====
`default_nettype none

module voice_loop_assert
(
    input wire        clk_12M,
    input wire        reset,
    input wire        path_ready,
    input wire        rx_req,
    input wire        rx_ack,
    input wire [15:0] rx_left,
    input wire [15:0] rx_right,
    input wire        fx_req,
    input wire        fx_ack,
    input wire [15:0] fx_left,
    input wire [15:0] fx_right
);

    timeunit 1ns;
    timeprecision 100ps;

    //////////////////////////////////////////////////
    // four-phase rules on rx_to_fx and fx_to_tx
    //////////////////////////////////////////////////
    rx_req_hold: assert property (@(posedge clk_12M) disable iff (reset || !path_ready)
        rx_req && !rx_ack |=> rx_req) else $error("rx_req dropped before rx_ack");
    fx_req_hold: assert property (@(posedge clk_12M) disable iff (reset || !path_ready)
        fx_req && !fx_ack |=> fx_req) else $error("fx_req dropped before fx_ack");

    rx_data_stable: assert property (@(posedge clk_12M) disable iff (reset || !path_ready)
        rx_req && !rx_ack |=> $stable(rx_left) && $stable(rx_right))
        else $error("rx data moved while offered");
    fx_data_stable: assert property (@(posedge clk_12M) disable iff (reset || !path_ready)
        fx_req && !fx_ack |=> $stable(fx_left) && $stable(fx_right))
        else $error("fx data moved while offered");

    rx_ack_release: assert property (@(posedge clk_12M) disable iff (reset || !path_ready)
        $fell(rx_ack) |-> !$past(rx_req)) else $error("rx_ack fell with rx_req high");
    fx_ack_release: assert property (@(posedge clk_12M) disable iff (reset || !path_ready)
        $fell(fx_ack) |-> !$past(fx_req)) else $error("fx_ack fell with fx_req high");

endmodule

bind voice_effect voice_loop_assert assert_i (.*);

`default_nettype wire

// ==== verif/voice_loop_tb.sv ====
`default_nettype none

module voice_loop_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_ns      = 20;
    localparam int frame_clks  = 256;                       // 32 sck of 8 cycles
    localparam int data_frames = 20 + 5 * 10 + 12 + 10 + 4; // all test segments
    localparam int segments    = 8;
    localparam int run_frames  = data_frames + segments * 6; // drain and idle per segment
    localparam int watchdog_ns = (run_frames + 8) * frame_clks * clk_ns
                               + 2 * voice_loop_pkg::powerup_cycles * clk_ns;

    logic        clk_12M;
    logic        reset;
    logic        key;
    logic [3:0]  key_diff;
    logic        sck;                  // shared by adc and dac ports
    logic        ws;
    logic        adc_sd;
    logic        dac_sd;
    logic        path_ready;
    logic        overrun;

    logic [31:0] drv_q[$];             // frames waiting for the codec model
    logic [4:0]  drv_key_q[$];         // {switch, new key} applied mid-frame
    logic [31:0] exp_q[$];
    logic [31:0] alt_q[$];             // other mode for the transition frame
    bit          either_q[$];
    logic [31:0] out_q[$];             // frames rebuilt from dac_sd
    int          frames_done = 0;
    int          errors = 0;
    bit          skipping = 1'b1;      // leading zero frames of a segment
    bit          discard = 1'b0;       // output frames around a key release

    voice_loop_top dut_i
    (
        .clk_12M    (clk_12M),
        .reset      (reset),
        .key        (key),
        .key_diff   (key_diff),
        .adc_sck    (sck),
        .adc_ws     (ws),
        .adc_sd     (adc_sd),
        .dac_sck    (sck),
        .dac_ws     (ws),
        .dac_sd     (dac_sd),
        .path_ready (path_ready),
        .overrun    (overrun)
    );

    initial
    begin
        clk_12M = 1'b0;
        forever #(clk_ns / 2) clk_12M = ~clk_12M;
    end

    //////////////////////////////////////////////////
    // reference model and checking
    //////////////////////////////////////////////////
    function automatic logic [31:0] expected_frame(input logic [3:0] mode,
                                                   input logic [15:0] l, input logic [15:0] r);
        int li;
        int ri;
        int half;
        li = int'($signed(l));
        ri = int'($signed(r));
        case (mode)
            4'b0001: return {l, l};
            4'b0010: return {r, r};
            4'b0100:
            begin
                half = (li + ri) >>> 1;           // floor of the centre
                return {half[15:0], half[15:0]};
            end
            4'b1000:
            begin
                half = (li - ri) >>> 1;           // floor of the side
                return {half[15:0], half[15:0]};
            end
            default: return {l, r};               // pass and unlisted keys
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    // output frames against the expected queue in order
    initial
    begin
        logic [31:0] got;
        logic [31:0] e;
        logic [31:0] a;
        bit          any;
        forever
        begin
            @(posedge clk_12M);
            while (out_q.size() > 0)
            begin
                got = out_q.pop_front();
                if (discard)
                    continue;
                if (exp_q.size() == 0)
                    check_value("dac idle frame", got, 32'h0);
                else if (!(skipping && got == 32'h0))
                begin
                    skipping = 1'b0;
                    e   = exp_q.pop_front();
                    a   = alt_q.pop_front();
                    any = either_q.pop_front();
                    if (!(any && got == a))
                        check_value("dac frame", got, e);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // codec bus model
    //////////////////////////////////////////////////
    initial
    begin
        logic [31:0] fr;
        logic [4:0]  kc;
        logic        prev_lsb;
        sck      = 1'b0;
        ws       = 1'b0;
        adc_sd   = 1'b0;
        prev_lsb = 1'b0;
        @(posedge clk_12M);
        #2;
        forever
        begin
            fr = 32'h0;                    // silence when nothing queued
            kc = 5'h0;
            if (drv_q.size() > 0)
            begin
                fr = drv_q.pop_front();
                kc = drv_key_q.pop_front();
            end
            for (int s = 0; s < 32; s++)
            begin
                sck    = 1'b0;             // data and ws change on falling sck
                ws     = (s >= 16);
                adc_sd = (s == 0) ? prev_lsb : fr[32 - s]; // MSB one slot after ws
                if (s == 16 && kc[4])
                    key_diff = kc[3:0];    // mid-frame key change
                repeat (4) @(posedge clk_12M);
                #2;
                sck = 1'b1;
                repeat (4) @(posedge clk_12M);
                #2;
            end
            prev_lsb = fr[0];
            frames_done++;
        end
    end

    // dac monitor samples just after rising sck
    initial
    begin
        logic [31:0] sh;
        logic        ws_last;
        sh      = 32'h0;
        ws_last = 1'b0;
        forever
        begin
            @(posedge sck);
            #1;
            sh = {sh[30:0], dac_sd};
            if (ws_last && !ws)
                out_q.push_back(sh);       // right LSB closes the frame
            ws_last = ws;
        end
    end

    //////////////////////////////////////////////////
    // sequence helpers
    //////////////////////////////////////////////////
    task automatic queue_frame(input logic [15:0] l, input logic [15:0] r,
                               input logic [3:0] mode, input logic [3:0] alt_mode,
                               input bit either, input logic [4:0] key_ctl);
        drv_q.push_back({l, r});
        drv_key_q.push_back(key_ctl);
        exp_q.push_back(expected_frame(mode, l, r));
        alt_q.push_back(expected_frame(alt_mode, l, r));
        either_q.push_back(either);
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frames_done + n;
        while (frames_done < target)
            @(posedge clk_12M);
    endtask

    task automatic drain_outputs();
        while (exp_q.size() > 0)
            @(posedge clk_12M);
        check_value("overrun", 32'(overrun), 1'b0);
    endtask

    // counts cycles to path_ready while the dac stays quiet
    task automatic measure_hold_off();
        int n;
        n = 0;
        while (!path_ready && n < 4 * voice_loop_pkg::powerup_cycles)
        begin
            check_value("dac_sd", 32'(dac_sd), 1'b0);
            @(posedge clk_12M);
            #2;
            n++;
        end
        check_value("hold-off cycles", n, voice_loop_pkg::powerup_cycles);
    endtask

    task automatic run_mode(input logic [3:0] mode, input int n, input bit extremes);
        int k;
        @(posedge clk_12M);
        #2;
        key_diff = mode;
        skipping = 1'b1;
        queue_frame(16'h1234, 16'h0102, mode, mode, 1'b0, 5'h0); // never a zero result
        k = 1;
        if (extremes)
        begin
            queue_frame(16'h8000, 16'h8000, mode, mode, 1'b0, 5'h0);
            queue_frame(16'h7fff, 16'h7fff, mode, mode, 1'b0, 5'h0);
            queue_frame(16'h8000, 16'h7fff, mode, mode, 1'b0, 5'h0);
            queue_frame(16'h7fff, 16'h8000, mode, mode, 1'b0, 5'h0);
            k = 5;
        end
        for (int i = k; i < n; i++)
            queue_frame(16'($urandom()), 16'($urandom()), mode, mode, 1'b0, 5'h0);
        drain_outputs();
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial
    begin
        void'($urandom(89145));
        reset    = 1'b1;
        key      = 1'b1;
        key_diff = voice_loop_pkg::mode_pass;
        repeat (2) @(posedge clk_12M);
        #2;
        check_value("path_ready in reset", 32'(path_ready), 1'b0);
        reset = 1'b0;
        measure_hold_off();
        wait_frames(2);

        run_mode(voice_loop_pkg::mode_pass, 20, 1'b0);
        run_mode(voice_loop_pkg::mode_left, 10, 1'b0);
        run_mode(voice_loop_pkg::mode_right, 10, 1'b0);
        run_mode(voice_loop_pkg::mode_no_music, 10, 1'b1);
        run_mode(voice_loop_pkg::mode_no_vocals, 10, 1'b1);
        run_mode(4'b0011, 10, 1'b0);

        // frame 5 sees the key change and may carry either mode
        @(posedge clk_12M);
        #2;
        key_diff = voice_loop_pkg::mode_no_vocals;
        skipping = 1'b1;
        queue_frame(16'h1234, 16'h0102, 4'b1000, 4'b1000, 1'b0, 5'h0);
        for (int i = 1; i < 12; i++)
        begin
            if (i < 5)
                queue_frame(16'($urandom()), 16'($urandom()), 4'b1000, 4'b1000, 1'b0, 5'h0);
            else if (i == 5)
                queue_frame(16'($urandom()), 16'($urandom()), 4'b0001, 4'b1000, 1'b1, 5'h11);
            else
                queue_frame(16'($urandom()), 16'($urandom()), 4'b0001, 4'b0001, 1'b0, 5'h0);
        end
        drain_outputs();

        // key release while a frame of ones is on the dac
        discard = 1'b1;
        for (int i = 0; i < 4; i++)
        begin
            drv_q.push_back(32'hffff_ffff);
            drv_key_q.push_back(5'h0);
        end
        while (dac_sd !== 1'b1)
        begin
            @(posedge clk_12M);
            #2;
        end
        key = 1'b0;
        repeat (20) @(posedge clk_12M);
        #2;
        check_value("path_ready with key released", 32'(path_ready), 1'b0);
        check_value("dac_sd with key released", 32'(dac_sd), 1'b0);
        key = 1'b1;
        measure_hold_off();
        wait_frames(5);                    // last frame of ones leaves the dac
        discard = 1'b0;
        run_mode(voice_loop_pkg::mode_pass, 10, 1'b0);

        $display("checks done, errors: %0d", errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        #(watchdog_ns);
        $display("timeout: the test sequence did not finish in %0d ns", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
